/* logic/pcm_params.svh */
/*
 * PCM sample player sizes
 * ROM address width, FIFO depth, pointer table base and strobe divide
 */
`ifndef PCM_PARAMS_SVH
`define PCM_PARAMS_SVH

// byte address into the sample ROM
`define PCM_AW          16

// sample bytes buffered between fetch and play, power of two
`define PCM_FIFO_DEPTH  16

// start of the two-byte pointer table, low byte first
`define PCM_TABLE_BASE  16'h0090

// strobe rising edges per play tick
`define PCM_STROBE_DIV  3

`endif

/* logic/pcm_pkg.sv */
/*
 * PCM sample player types
 * sample, address, gain and sound widths, fetch states and the level to gain map
 */
`include "pcm_params.svh"

package pcm_pkg;

    typedef logic [7:0]          pcm_byte_t;
    typedef logic [`PCM_AW-1:0]  pcm_addr_t;
    typedef logic [5:0]          pcm_idx_t;
    typedef logic [1:0]          pcm_level_t;
    typedef logic [7:0]          pcm_gain_t;
    typedef logic signed [15:0]  pcm_snd_t;

    // pointer low byte, pointer high byte, then the sample bytes
    typedef enum logic [1:0] {
        IDLE,
        PTR_LO,
        PTR_HI,
        STREAM
    } fetch_st_e;

    // effects level to PCM gain
    function automatic pcm_gain_t level_gain(input pcm_level_t level);
        pcm_gain_t g;
        case (level)
            2'd0:    g = 8'h00;
            2'd1:    g = 8'h05;
            2'd2:    g = 8'h0A;
            default: g = 8'h14;
        endcase
        return g;
    endfunction

endpackage

/* logic/pcm_stream_if.sv */
/*
 * Sample byte stream
 * carries bytes with an end marker from fetcher to FIFO and FIFO to player
 */
interface pcm_stream_if;

    // entry offered (fetch side) or entry available (play side)
    logic               push;
    pcm_pkg::pcm_byte_t data;
    // end of sample, data is not played
    logic               last;
    // FIFO full (fetch side) or pop strobe (play side)
    logic               full;
    // empties the FIFO, fetch side only
    logic               flush;

    modport src (
        output push, data, last, flush,
        input  full
    );

    modport buf_in (
        input  push, data, last, flush,
        output full
    );

    modport buf_out (
        output push, data, last,
        input  full
    );

    modport sink (
        input  push, data, last,
        output full
    );

endinterface

/* logic/pcm_fetch.sv */
/*
 * PCM fetcher
 * reads the start address from the pointer table on a trigger edge, then
 * streams sample bytes from ROM into the FIFO until a zero byte or 0xFFFF
 */
`include "pcm_params.svh"

module pcm_fetch (
    input  logic               clk,
    input  logic               comb_rstn,
    input  logic               trig,
    input  pcm_pkg::pcm_idx_t  trig_idx,
    output logic               pcm_cs,
    output pcm_pkg::pcm_addr_t pcm_addr,
    input  pcm_pkg::pcm_byte_t pcm_data,
    input  logic               pcm_ok,
    output logic               active,
    pcm_stream_if.src          st
);

    pcm_pkg::fetch_st_e state;
    pcm_pkg::pcm_byte_t ptr_lo;
    pcm_pkg::pcm_byte_t hold;
    pcm_pkg::pcm_addr_t tbl_addr;
    logic               trig_l;
    logic               trig_edge;
    logic               rom_done;
    logic               hold_vld;
    logic               hold_last;

    assign trig_edge = trig & ~trig_l;
    assign rom_done  = pcm_cs & pcm_ok;

    // two bytes per table entry
    assign tbl_addr = pcm_pkg::pcm_addr_t'(`PCM_TABLE_BASE)
                    + pcm_pkg::pcm_addr_t'({trig_idx, 1'b0});

    assign st.push  = hold_vld;
    assign st.data  = hold;
    assign st.last  = hold_last;
    assign st.flush = trig_edge;

    assign active = (state != pcm_pkg::IDLE);

    // ROM data capture
    always_ff @(posedge clk) begin
        if (rom_done) begin
            if (state == pcm_pkg::PTR_LO) begin
                ptr_lo <= pcm_data;
            end
            if (state == pcm_pkg::STREAM) begin
                hold <= pcm_data;
            end
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            trig_l    <= 1'b0;
            state     <= pcm_pkg::IDLE;
            pcm_cs    <= 1'b0;
            pcm_addr  <= '0;
            hold_vld  <= 1'b0;
            hold_last <= 1'b0;
        end else begin
            trig_l <= trig;
            if (trig_edge) begin
                // restart from any state, the FIFO is flushed in this cycle
                state     <= pcm_pkg::PTR_LO;
                pcm_cs    <= 1'b1;
                pcm_addr  <= tbl_addr;
                hold_vld  <= 1'b0;
                hold_last <= 1'b0;
            end else begin
                case (state)
                    pcm_pkg::PTR_LO: begin
                        if (rom_done) begin
                            pcm_cs   <= 1'b0;
                            pcm_addr <= pcm_addr + 1'b1;
                            state    <= pcm_pkg::PTR_HI;
                        end
                    end
                    pcm_pkg::PTR_HI: begin
                        if (!pcm_cs) begin
                            pcm_cs <= 1'b1;
                        end else if (pcm_ok) begin
                            pcm_cs   <= 1'b0;
                            pcm_addr <= {pcm_data, ptr_lo};
                            state    <= pcm_pkg::STREAM;
                        end
                    end
                    pcm_pkg::STREAM: begin
                        if (hold_vld) begin
                            // hold the byte until the FIFO takes it
                            if (!st.full) begin
                                hold_vld <= 1'b0;
                                if (hold_last) begin
                                    state <= pcm_pkg::IDLE;
                                end
                            end
                        end else if (!pcm_cs) begin
                            pcm_cs <= 1'b1;
                        end else if (pcm_ok) begin
                            pcm_cs    <= 1'b0;
                            hold_vld  <= 1'b1;
                            // zero byte or top of ROM ends the sample
                            hold_last <= (pcm_data == 8'h00) || (&pcm_addr);
                            pcm_addr  <= pcm_addr + 1'b1;
                        end
                    end
                    default: begin
                        pcm_cs <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* logic/pcm_fifo.sv */
/*
 * PCM sample FIFO
 * circular buffer of sample bytes with end markers, flushed on retrigger
 */
`include "pcm_params.svh"

module pcm_fifo (
    input  logic          clk,
    input  logic          comb_rstn,
    pcm_stream_if.buf_in  wr,
    pcm_stream_if.buf_out rd,
    output logic          empty
);

    localparam int DEPTH = `PCM_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    // entry is {last, byte}
    logic [8:0]    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          do_push;
    logic          do_pop;

    // flush wins over both ends
    assign do_push = wr.push & ~wr.full & ~wr.flush;
    assign do_pop  = rd.full & rd.push & ~wr.flush;

    assign wr.full = (count == (PW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign rd.push = ~empty;
    assign rd.data = mem[rd_ptr][7:0];
    assign rd.last = mem[rd_ptr][8];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {wr.last, wr.data};
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (wr.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/pcm_play.sv */
/*
 * PCM player
 * divides the sample strobe into play ticks, takes one byte per tick,
 * removes the 0x80 offset and scales it by the effects gain
 */
`include "pcm_params.svh"

module pcm_play (
    input  logic                clk,
    input  logic                comb_rstn,
    input  logic                sample,
    input  pcm_pkg::pcm_level_t fx_level,
    pcm_stream_if.sink          rd,
    output pcm_pkg::pcm_snd_t   snd
);

    localparam int DIV = `PCM_STROBE_DIV;

    logic [DIV-1:0]     ring;
    logic               sample_l;
    logic               rise;
    logic               tick;
    pcm_pkg::pcm_byte_t held;
    pcm_pkg::pcm_gain_t gain;
    logic signed [8:0]  offs;

    assign rise = sample & ~sample_l;

    // pop only when the FIFO has an entry
    assign rd.full = tick & rd.push;

    // unsigned byte to signed, midpoint 0x80
    assign offs = $signed({1'b0, held}) - 9'sd128;

    // one-hot ring, a tick after every DIV-th strobe edge
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            sample_l <= 1'b0;
            ring     <= DIV'(1);
            tick     <= 1'b0;
        end else begin
            sample_l <= sample;
            tick     <= 1'b0;
            if (rise) begin
                ring <= {ring[DIV-2:0], ring[DIV-1]};
                tick <= ring[DIV-1];
            end
        end
    end

    // held byte stays put on an empty FIFO
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            held <= 8'h80;
        end else if (rd.full) begin
            held <= rd.last ? 8'h80 : rd.data;
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            gain <= '0;
            snd  <= '0;
        end else begin
            gain <= pcm_pkg::level_gain(fx_level);
            snd  <= pcm_pkg::pcm_snd_t'(offs)
                  * pcm_pkg::pcm_snd_t'($signed({1'b0, gain}));
        end
    end

endmodule

/* logic/pcm_snd.sv */
/*
 * PCM sample player top
 * fetcher, sample FIFO and player joined by two byte streams
 */
module pcm_snd (
    input  logic                clk,
    input  logic                comb_rstn,
    // sound CPU port
    input  logic                trig,
    input  pcm_pkg::pcm_idx_t   trig_idx,
    // sample ROM
    output logic                pcm_cs,
    output pcm_pkg::pcm_addr_t  pcm_addr,
    input  pcm_pkg::pcm_byte_t  pcm_data,
    input  logic                pcm_ok,
    // strobe from the FM chip
    input  logic                sample,
    input  pcm_pkg::pcm_level_t fx_level,
    output pcm_pkg::pcm_snd_t   snd,
    output logic                busy
);

    logic active;
    logic fifo_empty;

    pcm_stream_if fetch_st ();
    pcm_stream_if play_st ();

    pcm_fetch u_fetch (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .trig      (trig),
        .trig_idx  (trig_idx),
        .pcm_cs    (pcm_cs),
        .pcm_addr  (pcm_addr),
        .pcm_data  (pcm_data),
        .pcm_ok    (pcm_ok),
        .active    (active),
        .st        (fetch_st)
    );

    pcm_fifo u_fifo (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .wr        (fetch_st),
        .rd        (play_st),
        .empty     (fifo_empty)
    );

    pcm_play u_play (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .sample    (sample),
        .fx_level  (fx_level),
        .rd        (play_st),
        .snd       (snd)
    );

    // busy until fetching is over and the last byte has left the FIFO
    assign busy = active | ~fifo_empty;

endmodule

/* tb/tb_clk.sv */
/*
 * Testbench clock
 * free-running 8 ns clock
 */
module tb_clk (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* tb/pcm_snd_tb.sv */
/*
 * PCM sample player testbench
 * behavioral sample ROM, trigger and strobe stimulus, and a reference model
 * of the pointer table, stop rules and gain, checked at every play tick
 */
`include "pcm_params.svh"

module pcm_snd_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 20000;
    localparam int TABLE_BASE = int'(`PCM_TABLE_BASE);
    localparam int STROBE_GAP = 16;
    localparam int PLAY_DELAY = 64;

    logic                clk;
    logic                comb_rstn;
    logic                trig;
    pcm_pkg::pcm_idx_t   trig_idx;
    logic                pcm_cs;
    pcm_pkg::pcm_addr_t  pcm_addr;
    pcm_pkg::pcm_byte_t  pcm_data;
    logic                pcm_ok = 1'b0;
    logic                sample = 1'b0;
    pcm_pkg::pcm_level_t fx_level;
    pcm_pkg::pcm_snd_t   snd;
    logic                busy;

    logic [7:0] rom [65536];
    int  lat_seed = 37;
    int  rom_cnt = 0;
    bit  rom_busy = 1'b0;
    int  cyc = 0;
    int  strobe_div = 0;
    bit  strobe_en = 1'b0;
    int  strobe_cnt = 0;
    int  tick_n = 0;
    int  checked_n = 0;
    int  chk_wait = 0;
    int  tick_errs = 0;
    int  tick_checks = 0;
    int  test_errs = 0;
    int  test_checks = 0;
    int  err_mark = 0;
    int  play_idx = 0;

    tb_clk u_clk (.clk(clk));

    pcm_snd u_dut (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .trig      (trig),
        .trig_idx  (trig_idx),
        .pcm_cs    (pcm_cs),
        .pcm_addr  (pcm_addr),
        .pcm_data  (pcm_data),
        .pcm_ok    (pcm_ok),
        .sample    (sample),
        .fx_level  (fx_level),
        .snd       (snd),
        .busy      (busy)
    );

    // ROM answers each select after a random wait with the data at the address
    assign pcm_data = pcm_ok ? rom[pcm_addr] : 8'h00;

    always @(posedge clk) begin
        if (pcm_ok) begin
            pcm_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (pcm_cs && !rom_busy) begin
            rom_busy <= 1'b1;
            rom_cnt  <= $random(lat_seed) & 32'h3;
        end else if (pcm_cs && rom_busy) begin
            if (rom_cnt == 0) begin
                pcm_ok <= 1'b1;
            end else begin
                rom_cnt <= rom_cnt - 1;
            end
        end
    end

    // one-cycle strobe every STROBE_GAP cycles while enabled
    always @(posedge clk) begin
        strobe_div <= (strobe_div == STROBE_GAP - 1) ? 0 : strobe_div + 1;
        sample     <= strobe_en && (strobe_div == 0);
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run did not finish");
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic int gain_for_level(input int level);
        case (level)
            0:       return 0;
            1:       return 5;
            2:       return 10;
            default: return 20;
        endcase
    endfunction

    // expected snd after a number of play ticks since the trigger
    function automatic logic [15:0] expect_snd(input logic [7:0] img [65536],
                                               input int idx, input int level,
                                               input int ticks);
        int base;
        int addr;
        int held;
        int b;
        int i;
        bit done;
        base = TABLE_BASE + 2 * idx;
        addr = int'(img[base[15:0]]) + (int'(img[base[15:0] + 16'd1]) << 8);
        held = 128;
        done = 1'b0;
        for (i = 0; i < ticks; i++) begin
            if (!done) begin
                b = int'(img[addr[15:0]]);
                if (b == 0 || addr == 65535) begin
                    held = 128;
                    done = 1'b1;
                end else begin
                    held = b;
                    addr = addr + 1;
                end
            end
        end
        return 16'((held - 128) * gain_for_level(level));
    endfunction

    function automatic bit check_value(input string name, input logic [15:0] exp,
                                       input logic [15:0] got);
        bit ok;
        ok = (got === exp);
        assert (ok) else $display("[ERROR] %s exp 0x%04h got 0x%04h", name, exp, got);
        return ok;
    endfunction

    // counts strobe edges like the DUT ring and checks snd after each tick
    always @(posedge clk) begin
        if (trig) begin
            tick_n    <= 0;
            checked_n <= 0;
        end
        if (sample) begin
            strobe_cnt <= strobe_cnt + 1;
            if ((strobe_cnt + 1) % `PCM_STROBE_DIV == 0) begin
                tick_n   <= tick_n + 1;
                chk_wait <= 4;
            end
        end else if (chk_wait > 0) begin
            if (chk_wait == 1) begin
                tick_checks <= tick_checks + 1;
                checked_n   <= checked_n + 1;
                if (!check_value("snd", expect_snd(rom, play_idx, int'(fx_level), tick_n),
                                 snd)) begin
                    tick_errs <= tick_errs + 1;
                end
            end
            chk_wait <= chk_wait - 1;
        end
    end

    task automatic write_sample(input int idx, input int start, input int len,
                                input bit term);
        int tbl;
        int a;
        int b;
        int i;
        tbl = TABLE_BASE + 2 * idx;
        rom[tbl[15:0]] = start[7:0];
        tbl = tbl + 1;
        rom[tbl[15:0]] = start[15:8];
        for (i = 0; i < len; i++) begin
            a = start + i;
            b = (i * 29 + idx * 71 + 17) % 256;
            if (b == 0) begin
                b = 1;
            end
            rom[a[15:0]] = b[7:0];
        end
        if (term) begin
            a = start + len;
            rom[a[15:0]] = 8'h00;
        end
    endtask

    task automatic load_rom();
        int a;
        for (a = 0; a < 65536; a++) begin
            rom[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h5A;
        end
        write_sample(3, 32'h0200, 10, 1'b1);
        write_sample(10, 32'h0400, 40, 1'b1);
        write_sample(5, 32'h0800, 30, 1'b1);
        write_sample(6, 32'h0A00, 20, 1'b1);
        // no terminator, runs into the top of the ROM
        write_sample(20, 32'hFFF8, 7, 1'b0);
        rom[16'hFFFF] = 8'h55;
    endtask

    task automatic expect_eq(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
        test_checks = test_checks + 1;
        if (!check_value(name, exp, got)) begin
            test_errs = test_errs + 1;
        end
    endtask

    task automatic trigger_sample(input int idx);
        @(posedge clk);
        play_idx <= idx;
        trig_idx <= 6'(idx);
        trig     <= 1'b1;
        repeat (2) @(posedge clk);
        trig <= 1'b0;
        repeat (PLAY_DELAY - 2) @(posedge clk);
    endtask

    task automatic play_ticks(input int n);
        @(posedge clk);
        strobe_en <= 1'b1;
        while (checked_n < n) begin
            @(posedge clk);
        end
        strobe_en <= 1'b0;
        repeat (STROBE_GAP) @(posedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = test_errs + tick_errs - err_mark;
        $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "failed", errs);
        err_mark = test_errs + tick_errs;
    endtask

    initial begin
        int level;
        comb_rstn = 1'b0;
        trig      = 1'b0;
        trig_idx  = '0;
        fx_level  = 2'd3;
        load_rom();
        repeat (10) @(posedge clk);
        comb_rstn <= 1'b1;
        @(posedge clk);

        expect_eq("pcm_cs", 16'h0, 16'(pcm_cs));
        expect_eq("busy", 16'h0, 16'(busy));
        expect_eq("snd", 16'h0, snd);
        finish_test(1, "reset values");

        trigger_sample(3);
        expect_eq("busy", 16'h1, 16'(busy));
        play_ticks(11);
        expect_eq("busy", 16'h0, 16'(busy));
        finish_test(2, "single playback");

        // longer than the FIFO so the fetcher stalls on full
        trigger_sample(10);
        play_ticks(41);
        expect_eq("busy", 16'h0, 16'(busy));
        finish_test(3, "back-pressure");

        trigger_sample(20);
        play_ticks(8);
        expect_eq("busy", 16'h0, 16'(busy));
        finish_test(4, "end at top of ROM");

        trigger_sample(5);
        play_ticks(6);
        expect_eq("busy", 16'h1, 16'(busy));
        trigger_sample(6);
        play_ticks(8);
        finish_test(5, "retrigger");

        // held byte of sample 6 under every gain
        for (level = 0; level < 4; level++) begin
            @(posedge clk);
            fx_level <= 2'(level);
            repeat (4) @(posedge clk);
            expect_eq("snd", expect_snd(rom, 6, level, tick_n), snd);
        end
        finish_test(6, "gain");

        $display("checks %0d, errors %0d", test_checks + tick_checks, test_errs + tick_errs);
        if (test_errs + tick_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* pcm_snd.f */
+incdir+logic
logic/pcm_pkg.sv
logic/pcm_stream_if.sv
logic/pcm_fetch.sv
logic/pcm_fifo.sv
logic/pcm_play.sv
logic/pcm_snd.sv
tb/tb_clk.sv
tb/pcm_snd_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := pcm_snd_tb
FILELIST  := pcm_snd.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) logic/pcm_params.svh
PASS_MSG  := ALL TESTS PASSED

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
